/* verif/link_testdata.txt */
// columns: command (0 LED, 1 CNTRL1, 2 CNTRL2, 3 DISPLAY), data word, idle gap in clk cycles
// four single frames first, then a burst of 20 words with no gap
0 12345678 50
1 ffffffff 50
2 00000000 50
3 80000001 50
0 deadbeef 0
1 cafef00d 0
2 0badc0de 0
3 13579bdf 0
0 2468ace0 0
1 fedcba98 0
2 76543210 0
3 a5a5a5a5 0
0 5a5a5a5a 0
1 00000001 0
2 c0000000 0
3 0f0f0f0f 0
0 f0f0f0f0 0
1 11111111 0
2 22222222 0
3 33333333 0
0 44444444 0
1 55555555 0
2 66666666 0
3 77777777 0

/* all.f */
+incdir+rtl
rtl/link_pkg.sv
rtl/frame_if.sv
rtl/word_hold.sv
rtl/link_tick_gen.sv
rtl/frame_fifo.sv
rtl/link_serializer.sv
rtl/link_tx_top.sv
verif/link_tx_tb.sv

/* Makefile */
# Verilator build and run for the link transmitter testbench

VERILATOR ?= verilator
TOP       ?= link_tx_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation passed

.PHONY: sim clean

# build, run, and succeed only if the pass message was printed
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* verif/link_tx_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "link_cfg.svh"

module link_tx_tb;
   import link_pkg::*;

   localparam int MAX_WORDS   = 64;
   localparam int CH_W        = `LINK_CH_W;
   localparam int HDR_BEATS   = `LINK_HDR_BEATS;
   localparam int LAST_BEAT   = `LINK_FRAME_BEATS - 1;
   localparam int READY_LIMIT = 2000;   // clk cycles allowed for one host window
   localparam int DRAIN_LIMIT = 5000;
   localparam int HOLD_LOW    = 8;      // plain handshake keeps rdy_for_data low 2 cycles

   logic        clk = 1'b0;
   logic        rst;
   logic [31:0] data_in;
   cmd_e        data_cmd;
   logic        data_rdy;
   logic        rdy_for_data;
   logic        com_clk;
   logic        com_req;
   logic        com_oe;
   logic [5:0]  com_channel;

   logic [31:0] stim [0:3*MAX_WORDS-1];   // cmd, word, gap per word
   logic [1:0]  exp_cmd [$];              // sent but not yet seen on the link
   logic [31:0] exp_data [$];
   int          n_words;
   int          errors;
   int          frames_done;
   int          beat_no;                  // 0 idle, 1 command, 2.. data
   int          low_run;
   int          max_low_run;
   logic        timed_out;
   logic [35:0] rx_word;
   logic [3:0]  cmds_seen;

   link_tx_top link_tx_top_i (
      .clk          (clk),
      .rst          (rst),
      .data_in      (data_in),
      .data_cmd     (data_cmd),
      .data_rdy     (data_rdy),
      .rdy_for_data (rdy_for_data),
      .com_clk      (com_clk),
      .com_req      (com_req),
      .com_oe       (com_oe),
      .com_channel  (com_channel)
   );

   always #10 clk = ~clk;   // 20 ns period

   // one-hot code with bit 0 for the first command
   function automatic logic [5:0] onehot_of(input logic [1:0] cmd);
      onehot_of = 6'b000001 << cmd;
   endfunction

   task automatic value_error(input string name, input logic [35:0] exp,
                              input logic [35:0] got);
      $display("** Error at %0d ns: %s expected 0x%0h got 0x%0h", $time, name, exp, got);
      errors++;
   endtask

   task automatic load_stimulus();
      for (int k = 0; k < 3 * MAX_WORDS; k++) begin
         stim[k] = '1;   // command field above 3 ends the list
      end
      $readmemh("verif/link_testdata.txt", stim);
      n_words = 0;
      while (n_words < MAX_WORDS && stim[3*n_words] <= 32'd3) begin
         n_words++;
      end
   endtask

   task automatic send_word(input int idx);
      int waited;
      waited = 0;
      @(negedge clk);
      while (!rdy_for_data && waited < READY_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (!rdy_for_data) begin
         $display("timed out waiting for rdy_for_data before word %0d", idx);
         timed_out = 1'b1;
      end else begin
         @(posedge clk);
         data_rdy <= 1'b1;
         data_cmd <= cmd_e'(stim[3*idx][1:0]);
         data_in  <= stim[3*idx+1];
         exp_cmd.push_back(stim[3*idx][1:0]);
         exp_data.push_back(stim[3*idx+1]);
         @(posedge clk);
         data_rdy <= 1'b0;
         repeat (stim[3*idx+2]) @(posedge clk);   // idle gap from the file
      end
   endtask

   task automatic wait_for_frames();
      int waited;
      waited = 0;
      while (frames_done < n_words && waited < DRAIN_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (frames_done < n_words) begin
         $display("timed out with %0d of %0d frames received", frames_done, n_words);
         timed_out = 1'b1;
      end
   endtask

   // longest stretch of rdy_for_data low as seen from the host side
   always @(negedge clk) begin
      if (rst || rdy_for_data) begin
         low_run = 0;
      end else begin
         low_run = low_run + 1;
         if (low_run > max_low_run) max_low_run = low_run;
      end
   end

   // link receiver sampling half a beat after the outputs move
   always @(posedge com_clk) begin
      if (beat_no == 0) begin
         assert (com_oe == 1'b0) else value_error("com_oe", 36'(1'b0), 36'(com_oe));
         if (com_req) begin
            if (exp_cmd.size() == 0) begin
               $display("frame started at %0d ns with no word waiting", $time);
               errors++;
            end
            rx_word = '0;
            beat_no = 1;
         end
      end else begin
         assert (com_req == 1'b0) else value_error("com_req", 36'(1'b0), 36'(com_req));
         assert (com_oe == 1'b1) else value_error("com_oe", 36'(1'b1), 36'(com_oe));
         if (beat_no == 1) begin
            if (exp_cmd.size() != 0) begin
               assert (com_channel == onehot_of(exp_cmd[0]))
               else value_error("com_channel", 36'(onehot_of(exp_cmd[0])), 36'(com_channel));
               cmds_seen[exp_cmd[0]] = 1'b1;
            end
         end else begin
            rx_word[(beat_no-HDR_BEATS)*CH_W +: CH_W] = com_channel;   // lsb slice first
         end
         if (beat_no == LAST_BEAT) begin
            assert (com_channel[5:2] == 4'b0000)
            else value_error("com_channel[5:2]", 36'(4'b0000), 36'(com_channel[5:2]));
            if (exp_data.size() != 0) begin
               assert (rx_word[31:0] == exp_data[0])
               else value_error("data word", 36'(exp_data[0]), rx_word);
               void'(exp_cmd.pop_front());
               void'(exp_data.pop_front());
            end
            frames_done++;
            beat_no = 0;
         end else begin
            beat_no++;
         end
      end
   end

   initial begin
      rst         = 1'b1;
      data_in     = '0;
      data_cmd    = CMD_LED;
      data_rdy    = 1'b0;
      errors      = 0;
      frames_done = 0;
      beat_no     = 0;
      low_run     = 0;
      max_low_run = 0;
      timed_out   = 1'b0;
      rx_word     = '0;
      cmds_seen   = '0;
      load_stimulus();
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      assert (rdy_for_data == 1'b1)
      else value_error("rdy_for_data", 36'(1'b1), 36'(rdy_for_data));
      assert (com_req == 1'b0) else value_error("com_req", 36'(1'b0), 36'(com_req));
      assert (com_oe == 1'b0) else value_error("com_oe", 36'(1'b0), 36'(com_oe));
      assert (com_clk == 1'b0) else value_error("com_clk", 36'(1'b0), 36'(com_clk));
      if (n_words == 0) begin
         $display("no words found in the stimulus file");
         errors++;
      end
      for (int i = 0; i < n_words && !timed_out; i++) begin
         send_word(i);
      end
      if (!timed_out) wait_for_frames();
      if (!timed_out) begin
         assert (max_low_run > HOLD_LOW)
         else begin
            $display("rdy_for_data never stayed low long enough to show back-pressure");
            errors++;
         end
         assert (cmds_seen == 4'hf)
         else begin
            $display("not every command value went over the link");
            errors++;
         end
      end
      $display("%0d errors, %0d of %0d frames checked, longest rdy_for_data low %0d cycles",
               errors, frames_done, n_words, max_low_run);
      if (errors == 0 && !timed_out) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* rtl/link_tx_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "link_cfg.svh"

module link_tx_top (
   input  logic           clk,
   input  logic           rst,
   input  logic [31:0]    data_in,
   input  link_pkg::cmd_e data_cmd,
   input  logic           data_rdy,
   output logic           rdy_for_data,
   output logic           com_clk,
   output logic           com_req,
   output logic           com_oe,
   output logic [5:0]     com_channel
);
   import link_pkg::*;

   logic tick;   // one cycle per link beat

   frame_if #(.payload_t(link_frame_t)) hold_q ();   // hold register to queue
   frame_if #(.payload_t(link_frame_t)) q_ser ();    // queue to serializer

   word_hold word_hold_i (
      .clk          (clk),
      .rst          (rst),
      .data_in      (data_in),
      .data_cmd     (data_cmd),
      .data_rdy     (data_rdy),
      .rdy_for_data (rdy_for_data),
      .out          (hold_q)
   );

   frame_fifo #(
      .payload_t (link_frame_t),
      .DEPTH     (`LINK_FIFO_DEPTH)
   ) frame_fifo_i (
      .clk (clk),
      .rst (rst),
      .in  (hold_q),
      .out (q_ser)
   );

   link_tick_gen link_tick_gen_i (
      .clk     (clk),
      .rst     (rst),
      .tick    (tick),
      .com_clk (com_clk)
   );

   link_serializer link_serializer_i (
      .clk         (clk),
      .rst         (rst),
      .tick        (tick),
      .in          (q_ser),
      .com_req     (com_req),
      .com_oe      (com_oe),
      .com_channel (com_channel)
   );

endmodule

`default_nettype wire

/* rtl/link_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "link_cfg.svh"

module link_serializer (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  tick,
   frame_if.snk                  in,
   output logic                  com_req,
   output logic                  com_oe,
   output logic [`LINK_CH_W-1:0] com_channel
);
   import link_pkg::*;

   localparam int                EXT_W     = `LINK_CH_W * `LINK_DATA_BEATS;
   localparam int                BEAT_W    = $clog2(`LINK_DATA_BEATS);
   localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`LINK_DATA_BEATS - 1);

   typedef enum logic [1:0] {
      IDLE,
      REQ,
      CMD,
      DATA
   } state_e;

   state_e            state;
   logic [BEAT_W-1:0] beat;        // current data beat
   logic [BEAT_W-1:0] beat_nxt;
   link_frame_t       frame;       // head of the queue
   logic [EXT_W-1:0]  frame_ext;   // word padded to whole beats
   logic              last_tick;   // tick closing the last data beat

   assign frame     = in.payload;
   assign frame_ext = EXT_W'(frame.data);   // top bits zero
   assign beat_nxt  = beat + 1'b1;
   assign last_tick = tick && (state == DATA) && (beat == LAST_BEAT);

   // entry leaves the queue only once fully sent
   assign in.ready = last_tick;

   // outputs move only on a tick so they settle before the com_clk rise
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state       <= IDLE;
         beat        <= '0;
         com_req     <= 1'b0;
         com_oe      <= 1'b0;
         com_channel <= '0;
      end else if (tick) begin
         case (state)
            IDLE: begin
               if (in.valid) begin
                  state   <= REQ;
                  com_req <= 1'b1;   // request beat, channel released
               end
            end
            REQ: begin
               state       <= CMD;
               com_req     <= 1'b0;
               com_oe      <= 1'b1;
               com_channel <= cmd_onehot(frame.cmd);
            end
            CMD: begin
               state       <= DATA;
               beat        <= '0;
               com_channel <= frame_ext[0 +: `LINK_CH_W];   // lsb slice first
            end
            DATA: begin
               if (beat == LAST_BEAT) begin
                  state       <= IDLE;   // next frame may start on the following tick
                  beat        <= '0;
                  com_oe      <= 1'b0;
                  com_channel <= '0;
               end else begin
                  beat        <= beat_nxt;
                  com_channel <= frame_ext[beat_nxt * `LINK_CH_W +: `LINK_CH_W];
               end
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* rtl/frame_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "link_cfg.svh"

module frame_fifo #(
   parameter type payload_t = logic,
   parameter int  DEPTH     = `LINK_FIFO_DEPTH
) (
   input  logic clk,
   input  logic rst,
   frame_if.snk in,
   frame_if.src out
);

   localparam int            AW       = $clog2(DEPTH);
   localparam logic [AW-1:0] LAST_IDX = AW'(DEPTH - 1);
   localparam logic [AW:0]   FULL_CNT = (AW + 1)'(DEPTH);

   payload_t      mem [DEPTH];   // entry storage
   logic [AW-1:0] wr_ptr;        // next slot to fill
   logic [AW-1:0] rd_ptr;        // oldest entry
   logic [AW:0]   count;         // entries held
   logic          push;
   logic          pop;

   assign in.ready    = (count != FULL_CNT);
   assign out.valid   = (count != '0);
   assign out.payload = mem[rd_ptr];   // visible the cycle after push

   assign push = in.valid & in.ready;
   assign pop  = out.valid & out.ready;

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= in.payload;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
         end
         // simultaneous push and pop leaves the count unchanged
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

/* rtl/link_tick_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "link_cfg.svh"

module link_tick_gen (
   input  logic clk,
   input  logic rst,
   output logic tick,
   output logic com_clk
);

   localparam int MSB = `LINK_DIV_LOG2 - 1;

   logic [`LINK_DIV_LOG2-1:0] div_cnt;   // free running divider
   logic                      clk_fall;  // com_clk about to drop

   // com_clk is high now and the next value is low
   assign clk_fall = com_clk & ~div_cnt[MSB];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         div_cnt <= '0;
         com_clk <= 1'b0;
         tick    <= 1'b0;
      end else begin
         div_cnt <= div_cnt + 1'b1;
         com_clk <= div_cnt[MSB];   // half period high, half low
         tick    <= clk_fall;       // same cycle com_clk goes low
      end
   end

   // receiver samples on the com_clk rise, half a beat after the tick

endmodule

`default_nettype wire

/* rtl/word_hold.sv */
`timescale 1ns/1ps
`default_nettype none

module word_hold (
   input  logic           clk,
   input  logic           rst,
   input  logic [31:0]    data_in,
   input  link_pkg::cmd_e data_cmd,
   input  logic           data_rdy,
   output logic           rdy_for_data,
   frame_if.src           out
);
   import link_pkg::*;

   link_frame_t hold_frame;   // captured command and word
   logic        hold_v;       // entry waiting for the queue
   logic        take;         // host strobe accepted this cycle
   logic        handed;       // queue took the entry

   // strobe while the window is closed is dropped
   assign take   = data_rdy & rdy_for_data;
   assign handed = hold_v & out.ready;

   // word and command latched on the host strobe
   always_ff @(posedge clk) begin
      if (take) begin
         hold_frame.cmd  <= data_cmd;
         hold_frame.data <= data_in;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         hold_v       <= 1'b0;
         rdy_for_data <= 1'b1;
      end else begin
         if (take) begin
            hold_v       <= 1'b1;   // offered to the queue next cycle
            rdy_for_data <= 1'b0;
         end else if (handed) begin
            hold_v <= 1'b0;   // entry now in the queue
         end else if (!hold_v && !rdy_for_data) begin
            rdy_for_data <= 1'b1;   // reopen one cycle after the handoff
         end
      end
   end

   // hold_v stays up until the queue has space
   assign out.valid   = hold_v;
   assign out.payload = hold_frame;

endmodule

`default_nettype wire

/* rtl/frame_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one frame entry moving between blocks under valid/ready
interface frame_if #(
   parameter type payload_t = logic
);

   logic     valid;     // entry offered
   logic     ready;     // entry accepted when both high
   payload_t payload;   // stable while valid

   // producer side
   modport src (
      output valid,
      output payload,
      input  ready
   );

   // consumer side
   modport snk (
      input  valid,
      input  payload,
      output ready
   );

endinterface

`default_nettype wire

/* rtl/link_pkg.sv */
`default_nettype none

package link_pkg;

   // width of the one-hot command code on the channel
   localparam int CMD_CODE_W = 6;

   // host word width
   localparam int LINK_DATA_W = 32;

   // command carried in the command beat
   typedef enum logic [1:0] {
      CMD_LED     = 2'd0,
      CMD_CNTRL1  = 2'd1,
      CMD_CNTRL2  = 2'd2,
      CMD_DISPLAY = 2'd3
   } cmd_e;

   // one queued frame entry, 34 bits
   typedef struct packed {
      cmd_e                   cmd;    // command code
      logic [LINK_DATA_W-1:0] data;   // host word
   } link_frame_t;

   // command index to the one-hot code sent on the wire
   function automatic logic [CMD_CODE_W-1:0] cmd_onehot(input cmd_e cmd);
      logic [CMD_CODE_W-1:0] code;
      code      = '0;
      code[cmd] = 1'b1;   // bit 0 is CMD_LED
      return code;
   endfunction

endpackage

`default_nettype wire

/* rtl/link_cfg.svh */
`ifndef LINK_CFG_SVH
`define LINK_CFG_SVH

// frames buffered between the hold register and the serializer
`define LINK_FIFO_DEPTH 16

// link beat lasts 2**LINK_DIV_LOG2 clk cycles
`define LINK_DIV_LOG2 3

// width of the link data channel
`define LINK_CH_W 6

// data beats per frame, 36 bits after zero extension
`define LINK_DATA_BEATS 6

// request and command beats that lead each frame
`define LINK_HDR_BEATS 2

// total beats on the wire per frame
`define LINK_FRAME_BEATS (`LINK_HDR_BEATS + `LINK_DATA_BEATS)

`endif
